//--- Bender.yml
package:
  name: byte_cpu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpu_isa_pkg.sv
      - rtl/cpu_bus_pkg.sv
      - rtl/cpu_ram.sv
      - rtl/cpu_alu.sv
      - rtl/cpu_datapath.sv
      - rtl/cpu_control.sv
      - rtl/cpu_top.sv
  - target: test
    files:
      - verif/cpu_sva.sv
      - verif/cpu_checker.sv
      - verif/cpu_tb.sv

//--- byte_cpu.f
+incdir+rtl
rtl/cpu_isa_pkg.sv
rtl/cpu_bus_pkg.sv
rtl/cpu_ram.sv
rtl/cpu_alu.sv
rtl/cpu_datapath.sv
rtl/cpu_control.sv
rtl/cpu_top.sv
verif/cpu_sva.sv
verif/cpu_checker.sv
verif/cpu_tb.sv

//--- rtl/byte_cpu_cfg.svh
`ifndef BYTE_CPU_CFG_SVH
`define BYTE_CPU_CFG_SVH

// Width of the shared bus and of every register
`define CPU_DATA_W 8

// General registers REG0 to REG7
`define CPU_NUM_REGS 8

// Words in the program and data RAM
`define CPU_RAM_DEPTH 256

`define CPU_SEL_W 5

`endif

//--- rtl/cpu_alu.sv
`timescale 1ns/1ps
`include "byte_cpu_cfg.svh"

module cpu_alu
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;
(
	input  logic [`CPU_DATA_W-1:0] i_a,
	input  logic [`CPU_DATA_W-1:0] i_b,
	input  alu_op_t                i_op,
	input  logic                   i_signed,
	output logic [`CPU_DATA_W-1:0] o_result,
	output logic [`CPU_DATA_W-1:0] o_flags
);
	localparam int MSB = `CPU_DATA_W - 1;

	// Result with the carry or borrow in the top bit
	logic [`CPU_DATA_W:0] m_wide;
	logic m_ovf;

	always_comb begin
		m_wide = '0;
		m_ovf = 1'b0;
		case (i_op)
			ALU_ADD: begin
				m_wide = {1'b0, i_a} + {1'b0, i_b};
				m_ovf = (i_a[MSB] == i_b[MSB]) && (m_wide[MSB] != i_a[MSB]);
			end
			ALU_SUB: begin
				m_wide = {1'b0, i_a} - {1'b0, i_b};
				m_ovf = (i_a[MSB] != i_b[MSB]) && (m_wide[MSB] != i_a[MSB]);
			end
			ALU_AND: m_wide = {1'b0, i_a & i_b};
			ALU_OR: m_wide = {1'b0, i_a | i_b};
			ALU_XOR: m_wide = {1'b0, i_a ^ i_b};
			ALU_NOTA: m_wide = {1'b0, ~i_a};
			ALU_SHL: m_wide = {i_a, 1'b0};
			ALU_SHR: m_wide = {1'b0, i_a >> 1};
			default: m_wide = '0;
		endcase
	end

	assign o_result = m_wide[MSB:0];

	always_comb begin
		o_flags = '0;
		// Top bit is only set by ADD, SUB and SHL
		o_flags[FLAG_CARRY] = m_wide[`CPU_DATA_W];
		o_flags[FLAG_EQUAL] = (i_a == i_b);
		o_flags[FLAG_LESS] = i_signed ? ($signed(i_a) < $signed(i_b)) : (i_a < i_b);
		o_flags[FLAG_ZERO] = (o_result == '0);
		o_flags[FLAG_ONE] = (o_result == `CPU_DATA_W'(1));
		o_flags[FLAG_OVERFLOW] = i_signed && m_ovf;
	end

endmodule

//--- rtl/cpu_bus_pkg.sv
`include "byte_cpu_cfg.svh"

package cpu_bus_pkg;

	// Shared bus sources that double as the register code byte of an instruction
	typedef enum logic [`CPU_SEL_W-1:0] {
		SEL_REG0  = 5'd0,
		SEL_REG1  = 5'd1,
		SEL_REG2  = 5'd2,
		SEL_REG3  = 5'd3,
		SEL_REG4  = 5'd4,
		SEL_REG5  = 5'd5,
		SEL_REG6  = 5'd6,
		SEL_REG7  = 5'd7,
		SEL_D_IN  = 5'd8,
		SEL_RAX   = 5'd9,
		SEL_RAM   = 5'd10,
		SEL_RIP   = 5'd11,
		SEL_RIP_1 = 5'd12,
		SEL_ZERO  = 5'd13
	} bus_sel_t;

	// Bit positions inside RFL where bits 7:6 always read zero
	typedef enum logic [2:0] {
		FLAG_CARRY    = 3'd0,
		FLAG_EQUAL    = 3'd1,
		FLAG_LESS     = 3'd2,
		FLAG_ZERO     = 3'd3,
		FLAG_ONE      = 3'd4,
		FLAG_OVERFLOW = 3'd5
	} flag_bit_t;

endpackage

//--- rtl/cpu_control.sv
`timescale 1ns/1ps
`include "byte_cpu_cfg.svh"

module cpu_control
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;
(
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_load_addr,
	input  logic                     i_load_data,
	input  logic                     i_execute,
	input  logic [`CPU_DATA_W-1:0]   i_ram_in,
	input  logic [`CPU_DATA_W-1:0]   i_alu_flags,
	output bus_sel_t                 o_select,
	output logic                     o_load_addr,
	output logic                     o_load_rip,
	output logic                     o_load_alu,
	output logic                     o_write_ram,
	output logic [`CPU_NUM_REGS-1:0] o_load_reg,
	output logic                     o_waiting,
	output logic                     o_take_input
);
	ctrl_state_t m_state;
	ctrl_state_t m_next_state;
	logic [2:0] m_step;

	// One-hot target for LDFI/LDFM, raw source code for STOM
	logic [`CPU_DATA_W-1:0] m_target;
	logic [`CPU_DATA_W-1:0] m_next_target;
	logic m_load_target;

	// Unknown opcodes fall through to HALT
	function automatic ctrl_state_t decode_op(input logic [`CPU_DATA_W-1:0] op_byte);
		case (op_byte)
			OP_NOOP: decode_op = ST_NOOP;
			OP_JUMP: decode_op = ST_JUMP;
			OP_MATH: decode_op = ST_MATH;
			OP_LDFM: decode_op = ST_LDFM;
			OP_LDFI: decode_op = ST_LDFI;
			OP_STOM: decode_op = ST_STOM;
			OP_JINZ: decode_op = ST_JINZ;
			OP_JIEQ: decode_op = ST_JIEQ;
			default: decode_op = ST_HALT;
		endcase
	endfunction

	always_comb begin
		m_next_state = m_state;
		case (m_state)
			ST_LOAD_ADDR: begin
				if (i_load_addr) m_next_state = ST_LOAD_ADDR_WAIT;
				else if (i_execute) m_next_state = ST_PRE_EXECUTE;
			end
			ST_LOAD_ADDR_WAIT: if (!i_load_addr) m_next_state = ST_LOAD_DATA;
			ST_LOAD_DATA: if (i_load_data) m_next_state = ST_LOAD_DATA_WAIT;
			ST_LOAD_DATA_WAIT: if (!i_load_data) m_next_state = ST_LOAD_ADDR;
			ST_PRE_EXECUTE: if (!i_execute) m_next_state = ST_FETCH;
			ST_FETCH, ST_INC_RIP: if (m_step == 3'd2) m_next_state = decode_op(i_ram_in);
			ST_HALT: m_next_state = ST_LOAD_ADDR;
			ST_NOOP: m_next_state = ST_INC_RIP;
			ST_JUMP: if (m_step == 3'd2) m_next_state = ST_FETCH;
			ST_MATH: if (m_step == 3'd2) m_next_state = ST_INC_RIP;
			ST_LDFI: if (m_step == 3'd3) m_next_state = ST_INC_RIP;
			ST_STOM: if (m_step == 3'd4) m_next_state = ST_INC_RIP;
			ST_LDFM: if (m_step == 3'd5) m_next_state = ST_INC_RIP;
			ST_JINZ: begin
				// A skipped jump leaves RIP on byte 1 for INC_RIP to step past
				if (m_step == 3'd0 && i_alu_flags[FLAG_ZERO]) m_next_state = ST_INC_RIP;
				else if (m_step == 3'd2) m_next_state = ST_FETCH;
			end
			ST_JIEQ: begin
				if (m_step == 3'd0 && !i_alu_flags[FLAG_EQUAL]) m_next_state = ST_INC_RIP;
				else if (m_step == 3'd2) m_next_state = ST_FETCH;
			end
			default: m_next_state = ST_LOAD_ADDR;
		endcase
	end

	always_comb begin
		o_select = SEL_ZERO;
		o_load_addr = 1'b0;
		o_load_rip = 1'b0;
		o_load_alu = 1'b0;
		o_write_ram = 1'b0;
		o_load_reg = '0;
		o_waiting = 1'b0;
		o_take_input = 1'b0;
		m_load_target = 1'b0;
		m_next_target = '0;
		case (m_state)
			ST_LOAD_ADDR: begin
				// MAR tracks the operator input
				o_select = SEL_D_IN;
				o_load_addr = 1'b1;
				o_waiting = 1'b1;
			end
			ST_LOAD_DATA: begin
				o_select = SEL_D_IN;
				o_write_ram = 1'b1;
				o_take_input = 1'b1;
			end
			ST_PRE_EXECUTE: begin
				o_load_rip = 1'b1;
				o_load_addr = 1'b1;
			end
			ST_FETCH: if (m_step == 3'd0) begin
				o_select = SEL_RIP;
				o_load_addr = 1'b1;
			end
			ST_INC_RIP, ST_MATH: begin
				if (m_step == 3'd0) begin
					o_select = SEL_RIP_1;
					o_load_rip = 1'b1;
					o_load_addr = 1'b1;
				end else if (m_step == 3'd2 && m_state == ST_MATH) begin
					// Operation byte is on the RAM output now
					o_load_alu = 1'b1;
				end
			end
			ST_JUMP, ST_JINZ, ST_JIEQ: begin
				if (m_step == 3'd0) begin
					o_select = SEL_RIP_1;
					o_load_rip = 1'b1;
					o_load_addr = 1'b1;
				end else if (m_step == 3'd2) begin
					o_select = SEL_RAM;
					o_load_rip = 1'b1;
				end
			end
			ST_LDFI, ST_LDFM, ST_STOM: begin
				case (m_step)
					3'd0, 3'd1: begin
						// Step onto byte 1, then byte 2
						o_select = SEL_RIP_1;
						o_load_rip = 1'b1;
						o_load_addr = 1'b1;
					end
					3'd2: begin
						m_load_target = 1'b1;
						if (m_state == ST_STOM) m_next_target = i_ram_in;
						else if (i_ram_in < `CPU_NUM_REGS) m_next_target[i_ram_in[2:0]] = 1'b1;
					end
					3'd3: begin
						o_select = SEL_RAM;
						if (m_state == ST_LDFI) o_load_reg = m_target;
						else o_load_addr = 1'b1;
					end
					3'd4: if (m_state == ST_STOM) begin
						o_select = bus_sel_t'(m_target[`CPU_SEL_W-1:0]);
						o_write_ram = 1'b1;
					end
					default: begin
						// Only LDFM gets this far
						o_select = SEL_RAM;
						o_load_reg = m_target;
					end
				endcase
			end
			default: ;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			m_state <= ST_LOAD_ADDR;
			m_step <= '0;
			m_target <= '0;
		end else begin
			m_state <= m_next_state;
			// Saturate so step 0 actions never repeat
			if (m_next_state != m_state) m_step <= '0;
			else if (m_step != 3'd7) m_step <= m_step + 3'd1;
			if (m_load_target) m_target <= m_next_target;
		end
	end

endmodule

//--- rtl/cpu_datapath.sv
`timescale 1ns/1ps
`include "byte_cpu_cfg.svh"

module cpu_datapath
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;
(
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic [`CPU_DATA_W-1:0]   i_data_in,
	input  bus_sel_t                 i_select,
	input  logic                     i_load_addr,
	input  logic                     i_load_rip,
	input  logic                     i_load_alu,
	input  logic                     i_write_ram,
	input  logic [`CPU_NUM_REGS-1:0] i_load_reg,
	output logic [`CPU_DATA_W-1:0]   o_ram_out,
	output logic [`CPU_DATA_W-1:0]   o_alu_flags
);
	logic [`CPU_DATA_W-1:0] m_mar;
	logic [`CPU_DATA_W-1:0] m_rip;
	logic [`CPU_DATA_W-1:0] m_rax;
	logic [`CPU_DATA_W-1:0] m_rfl;
	logic [`CPU_DATA_W-1:0] m_regs [`CPU_NUM_REGS];
	logic [`CPU_DATA_W-1:0] m_bus;
	logic [`CPU_DATA_W-1:0] m_alu_result;
	logic [`CPU_DATA_W-1:0] m_alu_flags;

	assign o_alu_flags = m_rfl;

	cpu_ram u_ram (
		.i_clk   (i_clk),
		.i_addr  (m_mar),
		.i_wdata (m_bus),
		.i_we    (i_write_ram),
		.o_rdata (o_ram_out)
	);

	// Bit 7 of the MATH operand byte picks signed mode and bits 2:0 the operation
	cpu_alu u_alu (
		.i_a      (m_regs[0]),
		.i_b      (m_regs[1]),
		.i_op     (alu_op_t'(o_ram_out[2:0])),
		.i_signed (o_ram_out[7]),
		.o_result (m_alu_result),
		.o_flags  (m_alu_flags)
	);

	always_comb begin
		case (i_select)
			SEL_REG0, SEL_REG1, SEL_REG2, SEL_REG3,
			SEL_REG4, SEL_REG5, SEL_REG6, SEL_REG7: m_bus = m_regs[i_select[2:0]];
			SEL_D_IN: m_bus = i_data_in;
			SEL_RAX: m_bus = m_rax;
			SEL_RAM: m_bus = o_ram_out;
			SEL_RIP: m_bus = m_rip;
			SEL_RIP_1: m_bus = m_rip + 1'b1;
			SEL_ZERO: m_bus = '0;
			default: m_bus = '0;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			m_mar <= '0;
			m_rip <= '0;
			m_rax <= '0;
			m_rfl <= '0;
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				m_regs[i] <= '0;
			end
		end else begin
			if (i_load_addr) m_mar <= m_bus;
			if (i_load_rip) m_rip <= m_bus;
			if (i_load_alu) begin
				m_rax <= m_alu_result;
				m_rfl <= m_alu_flags;
			end
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				if (i_load_reg[i]) m_regs[i] <= m_bus;
			end
		end
	end

endmodule

//--- rtl/cpu_isa_pkg.sv
`include "byte_cpu_cfg.svh"

package cpu_isa_pkg;

	// First byte of every instruction
	typedef enum logic [`CPU_DATA_W-1:0] {
		OP_HALT = 8'h00,
		OP_NOOP = 8'h01,
		OP_JUMP = 8'h03,
		OP_MATH = 8'h04,
		OP_LDFM = 8'h05,
		OP_LDFI = 8'h06,
		OP_STOM = 8'h09,
		OP_JINZ = 8'h0a,
		OP_JIEQ = 8'h0b
	} opcode_t;

	// Low three bits of the MATH operand byte
	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_AND  = 3'd2,
		ALU_OR   = 3'd3,
		ALU_XOR  = 3'd4,
		ALU_NOTA = 3'd5,
		ALU_SHL  = 3'd6,
		ALU_SHR  = 3'd7
	} alu_op_t;

	typedef enum logic [3:0] {
		ST_LOAD_ADDR, ST_LOAD_ADDR_WAIT, ST_LOAD_DATA, ST_LOAD_DATA_WAIT,
		ST_PRE_EXECUTE, ST_FETCH, ST_INC_RIP,
		ST_HALT, ST_NOOP, ST_JUMP, ST_MATH, ST_LDFM, ST_LDFI, ST_STOM,
		ST_JINZ, ST_JIEQ
	} ctrl_state_t;

endpackage

//--- rtl/cpu_ram.sv
`timescale 1ns/1ps
`include "byte_cpu_cfg.svh"

module cpu_ram (
	input  logic                               i_clk,
	input  logic [$clog2(`CPU_RAM_DEPTH)-1:0]  i_addr,
	input  logic [`CPU_DATA_W-1:0]             i_wdata,
	input  logic                               i_we,
	output logic [`CPU_DATA_W-1:0]             o_rdata
);
	logic [`CPU_DATA_W-1:0] m_mem [`CPU_RAM_DEPTH];

	// Read-during-write returns the old word
	always_ff @(posedge i_clk) begin
		if (i_we) begin
			m_mem[i_addr] <= i_wdata;
		end
		o_rdata <= m_mem[i_addr];
	end

endmodule

//--- rtl/cpu_top.sv
`timescale 1ns/1ps
`include "byte_cpu_cfg.svh"

module cpu_top
	import cpu_bus_pkg::*;
(
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic                   i_load_addr,
	input  logic                   i_load_data,
	input  logic                   i_execute,
	input  logic [`CPU_DATA_W-1:0] i_data_in,
	output logic [`CPU_DATA_W-1:0] o_data_out,
	output logic                   o_waiting,
	output logic                   o_take_input
);
	bus_sel_t m_select;
	logic m_load_addr;
	logic m_load_rip;
	logic m_load_alu;
	logic m_write_ram;
	logic [`CPU_NUM_REGS-1:0] m_load_reg;
	logic [`CPU_DATA_W-1:0] m_ram_out;
	logic [`CPU_DATA_W-1:0] m_alu_flags;

	// Operator sees the word at MAR
	assign o_data_out = m_ram_out;

	cpu_control u_control (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_load_addr  (i_load_addr),
		.i_load_data  (i_load_data),
		.i_execute    (i_execute),
		.i_ram_in     (m_ram_out),
		.i_alu_flags  (m_alu_flags),
		.o_select     (m_select),
		.o_load_addr  (m_load_addr),
		.o_load_rip   (m_load_rip),
		.o_load_alu   (m_load_alu),
		.o_write_ram  (m_write_ram),
		.o_load_reg   (m_load_reg),
		.o_waiting    (o_waiting),
		.o_take_input (o_take_input)
	);

	cpu_datapath u_datapath (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_data_in   (i_data_in),
		.i_select    (m_select),
		.i_load_addr (m_load_addr),
		.i_load_rip  (m_load_rip),
		.i_load_alu  (m_load_alu),
		.i_write_ram (m_write_ram),
		.i_load_reg  (m_load_reg),
		.o_ram_out   (m_ram_out),
		.o_alu_flags (m_alu_flags)
	);

endmodule

//--- verif/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
	input logic [7:0] i_data_out
);
	int m_pass_count;
	int m_fail_count;

	initial begin
		m_pass_count = 0;
		m_fail_count = 0;
	end

	// Compares the byte the DUT shows at the read-back address
	task automatic check_byte(input string name, input logic [7:0] expected);
		logic [7:0] actual;
		actual = i_data_out;
		if (actual === expected) begin
			m_pass_count++;
			$display("PASS %s: read 0x%02h", name, actual);
		end else begin
			m_fail_count++;
			$display("ERR %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
		end
	endtask

	// Reports a failure that is not a wrong value, like a stuck handshake
	task automatic note_failure(input string name, input string what);
		m_fail_count++;
		$display("FAIL %s: %s", name, what);
	endtask

	task automatic report_counts();
		$display("Checks run %0d, passed %0d, failed %0d",
			m_pass_count + m_fail_count, m_pass_count, m_fail_count);
	endtask

	function automatic bit all_passed();
		all_passed = (m_fail_count == 0) && (m_pass_count > 0);
	endfunction

endmodule

//--- verif/cpu_sva.sv
`timescale 1ns/1ps

module cpu_sva (
	input logic i_clk,
	input logic i_reset,
	input logic i_execute,
	input logic o_waiting,
	input logic o_take_input
);
	// High from the press of execute until the machine is back in LOAD_ADDR
	logic m_running;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			m_running <= 1'b0;
		end else if (o_waiting && i_execute) begin
			m_running <= 1'b1;
		end else if (o_waiting) begin
			m_running <= 1'b0;
		end
	end

	a_modes_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_waiting && o_take_input))
		else $error("o_waiting and o_take_input are high in the same cycle");

	a_waiting_after_reset: assert property (@(posedge i_clk)
		$fell(i_reset) |-> o_waiting)
		else $error("o_waiting is low in the first cycle after reset");

	a_no_input_while_running: assert property (@(posedge i_clk) disable iff (i_reset)
		m_running |-> !$rose(o_take_input))
		else $error("o_take_input rose while a program was running");

endmodule

//--- verif/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
	localparam int PROG_BYTES = 20;
	localparam int HS_LIMIT = 20;
	localparam int RUN_LIMIT = 2000;

	logic       i_clk;
	logic       i_reset;
	logic       i_load_addr;
	logic       i_load_data;
	logic       i_execute;
	logic [7:0] i_data_in;
	logic [7:0] o_data_out;
	logic       o_waiting;
	logic       o_take_input;

	// Test table with one entry per row in each queue
	string        m_names[$];
	int           m_lens[$];
	logic [159:0] m_progs[$];
	logic [7:0]   m_pre_addr[$];
	logic [15:0]  m_pre_data[$];
	logic [7:0]   m_res_addr[$];
	logic [7:0]   m_expect[$];
	bit           m_aborted;

	cpu_top i_dut (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_load_addr  (i_load_addr),
		.i_load_data  (i_load_data),
		.i_execute    (i_execute),
		.i_data_in    (i_data_in),
		.o_data_out   (o_data_out),
		.o_waiting    (o_waiting),
		.o_take_input (o_take_input)
	);

	cpu_checker u_checker (
		.i_data_out (o_data_out)
	);

	bind cpu_top cpu_sva u_sva (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_execute    (i_execute),
		.o_waiting    (o_waiting),
		.o_take_input (o_take_input)
	);

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	// Program bytes are written left to right and unused bytes read as HALT
	task automatic add_row(input string name, input int len, input logic [159:0] code,
		input logic [7:0] pre_addr, input logic [15:0] pre_data,
		input logic [7:0] res_addr, input logic [7:0] expected);
		m_names.push_back(name);
		m_lens.push_back(len);
		m_progs.push_back(code);
		m_pre_addr.push_back(pre_addr);
		m_pre_data.push_back(pre_data);
		m_res_addr.push_back(res_addr);
		m_expect.push_back(expected);
	endtask

	function automatic logic [7:0] prog_byte(input int row, input int idx);
		if (idx < m_lens[row]) prog_byte = m_progs[row][8*(m_lens[row]-1-idx) +: 8];
		else prog_byte = 8'h00;
	endfunction

	// Samples at each rising edge until the output reaches the level
	task automatic wait_level(input string name, input bit use_take, input logic level,
		input int limit, input string what, output bit ok);
		int n;
		n = 0;
		ok = 1'b0;
		@(posedge i_clk);
		while (!ok && n < limit) begin
			if ((use_take ? o_take_input : o_waiting) == level) ok = 1'b1;
			else begin
				@(posedge i_clk);
				n++;
			end
		end
		if (!ok) u_checker.note_failure(name, what);
	endtask

	task automatic load_byte(input string name, input logic [7:0] addr,
		input logic [7:0] data, output bit ok);
		i_data_in <= addr;
		i_load_addr <= 1'b1;
		wait_level(name, 1'b0, 1'b0, HS_LIMIT, "address press was not accepted", ok);
		if (ok) begin
			i_load_addr <= 1'b0;
			i_data_in <= data;
			wait_level(name, 1'b1, 1'b1, HS_LIMIT, "data phase never started", ok);
		end
		if (ok) begin
			i_load_data <= 1'b1;
			wait_level(name, 1'b1, 1'b0, HS_LIMIT, "data press was not accepted", ok);
		end
		if (ok) begin
			i_load_data <= 1'b0;
			wait_level(name, 1'b0, 1'b1, HS_LIMIT, "loader did not return to address phase", ok);
		end
	endtask

	task automatic run_program(input string name, output bit ok);
		i_execute <= 1'b1;
		wait_level(name, 1'b0, 1'b0, HS_LIMIT, "execute press was not accepted", ok);
		if (ok) begin
			i_execute <= 1'b0;
			wait_level(name, 1'b0, 1'b1, RUN_LIMIT, "program never halted", ok);
		end
	endtask

	task automatic build_table();
		add_row("load_scatter_a", 1, 'h00, 8'ha7, 16'h5c00, 8'ha7, 8'h5c);
		add_row("load_scatter_b", 1, 'h00, 8'h3e, 16'hc12b, 8'h3f, 8'h2b);
		add_row("load_addr0_kept", 1, 'h00, 8'hf0, 16'h9998, 8'h00, 8'h00);
		add_row("load_earlier_kept", 1, 'h00, 8'hf0, 16'h9998, 8'ha7, 8'h5c);
		add_row("ldfi_stom", 7, 'h06036d_090380_00, 8'h80, 16'h1112, 8'h80, 8'h6d);
		add_row("ldfi_bad_reg", 10, 'h060233_060a77_090281_00, 8'h81, 16'h5555, 8'h81, 8'h33);
		add_row("math_add", 12, 'h050090_050191_0400_090992_00, 8'h90, 16'hc85a, 8'h92, 8'h22);
		add_row("math_sub", 12, 'h050090_050191_0401_090993_00, 8'h90, 16'h3045, 8'h93, 8'heb);
		add_row("math_xor", 12, 'h050090_050191_0404_090994_00, 8'h90, 16'ha53c, 8'h94, 8'h99);
		add_row("jieq_taken", 18, 'h060042_060142_0400_0b0e_0900a0_00_0909a0_00,
			8'ha0, 16'hffff, 8'ha0, 8'h84);
		add_row("jieq_skip", 18, 'h060042_060141_0400_0b0e_0900a1_00_0909a1_00,
			8'ha1, 16'hffff, 8'ha1, 8'h42);
		add_row("jinz_taken", 18, 'h060005_060103_0401_0a0e_0900a2_00_0909a2_00,
			8'ha2, 16'hffff, 8'ha2, 8'h02);
		add_row("jinz_skip", 18, 'h060007_060107_0401_0a0e_0900a3_00_0909a3_00,
			8'ha3, 16'hffff, 8'ha3, 8'h07);
		add_row("signed_sub_skip", 18, 'h060080_060101_0481_0b0e_0909a4_00_0900a4_00,
			8'ha4, 16'hffff, 8'ha4, 8'h7f);
		add_row("jump_over", 15, 'h0600ee_0308_0900b0_010101_0900b1_00,
			8'hb0, 16'h5a00, 8'hb0, 8'h5a);
		add_row("jump_noops_store", 15, 'h0600ee_0308_0900b0_010101_0900b1_00,
			8'hb0, 16'h5a00, 8'hb1, 8'hee);
		add_row("unknown_halts", 8, 'h06003c_ff_0900c0_00, 8'hc0, 16'h7778, 8'hc0, 8'h77);
	endtask

	initial begin
		bit ok;
		i_reset = 1'b1;
		i_load_addr = 1'b0;
		i_load_data = 1'b0;
		i_execute = 1'b0;
		i_data_in = 8'h00;
		m_aborted = 1'b0;
		build_table();
		repeat (8) @(posedge i_clk);
		i_reset <= 1'b0;
		for (int row = 0; row < m_names.size(); row++) begin
			ok = !m_aborted;
			for (int i = 0; i < PROG_BYTES && ok; i++) begin
				load_byte(m_names[row], i[7:0], prog_byte(row, i), ok);
			end
			if (ok) load_byte(m_names[row], m_pre_addr[row], m_pre_data[row][15:8], ok);
			if (ok) load_byte(m_names[row], m_pre_addr[row] + 8'd1, m_pre_data[row][7:0], ok);
			if (ok) run_program(m_names[row], ok);
			if (ok) begin
				// MAR follows the input, then one more edge for the RAM read
				i_data_in <= m_res_addr[row];
				repeat (3) @(posedge i_clk);
				u_checker.check_byte(m_names[row], m_expect[row]);
			end else begin
				m_aborted = 1'b1;
			end
		end
		u_checker.report_counts();
		if (!m_aborted && u_checker.all_passed()) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
